// ==== Bender.yml ====
package:
  name: dispatch

sources:
  - dispatch_pkg.sv
  - rob_alloc.sv
  - rob_store.sv
  - instr_dispatcher.sv
  - fu_busy_tracker.sv
  - dispatch_top.sv
  - target: simulation
    files:
      - tb_dispatch_top.sv

// ==== dispatch.f ====
dispatch_pkg.sv
rob_alloc.sv
rob_store.sv
instr_dispatcher.sv
fu_busy_tracker.sv
dispatch_top.sv
tb_dispatch_top.sv

// ==== dispatch_pkg.sv ====
package dispatch_pkg;

	// ======================================================================
	// reorder buffer and register file sizes
	// ======================================================================

	// slot count of the reorder buffer, a power of two so indices wrap freely
	localparam int ROB_ENTRIES = 8;
	typedef logic [$clog2(ROB_ENTRIES)-1:0] rob_ndx_t;

	localparam int NUM_AREGS = 8;
	typedef logic [$clog2(NUM_AREGS)-1:0] areg_t;

	// ======================================================================
	// functional units
	// ======================================================================

	localparam int NUM_FU = 5;
	typedef logic [2:0] fu_id_t;

	localparam fu_id_t FU_ALU0 = 3'd0;
	localparam fu_id_t FU_ALU1 = 3'd1;
	localparam fu_id_t FU_MUL  = 3'd2;
	localparam fu_id_t FU_MEM  = 3'd3;
	localparam fu_id_t FU_FCU  = 3'd4;

	// fixed execution latency of each unit class, in cycles
	localparam int LAT_ALU = 1;
	localparam int LAT_MUL = 3;
	localparam int LAT_MEM = 2;
	localparam int LAT_FCU = 1;

	typedef enum logic [2:0] {
		OP_NOP, OP_ADD, OP_SUB, OP_MUL, OP_LOAD, OP_STORE, OP_BR
	} op_e;

	typedef enum logic [1:0] {FC_ALU, FC_MUL, FC_MEM, FC_FCU} fu_class_e;

	// ======================================================================
	// records
	// ======================================================================

	// decoded instruction as it arrives from the front end, 20 bits
	typedef struct packed {
		op_e op;
		areg_t rd;
		areg_t rs1;
		areg_t rs2;
		logic [7:0] imm;
	} instr_t;

	// one reorder buffer slot; a dependency names the producing slot
	typedef struct packed {
		logic v;
		instr_t instr;
		fu_class_e fcls;
		logic dep1_v;
		rob_ndx_t dep1_ndx;
		logic dep2_v;
		rob_ndx_t dep2_ndx;
		logic out;
		logic done;
	} rob_entry_t;

	typedef struct packed {
		logic v;
		rob_ndx_t ndx;
		instr_t instr;
		fu_id_t fu;
	} dispatch_t;

	// used both for unit completions and for the retiring slot
	typedef struct packed {
		logic v;
		rob_ndx_t ndx;
	} complete_t;

endpackage

// ==== dispatch_top.sv ====
`timescale 1ns/1ps

module dispatch_top import dispatch_pkg::*; #(
	parameter int DISPATCH_COUNT = 4
) (
	input logic clk,
	input logic rst,
	input logic alloc_valid_i,
	input instr_t alloc_instr_i,
	output logic alloc_ready_o,
	output dispatch_t [DISPATCH_COUNT-1:0] dispatch_o,
	output logic retire_valid_o,
	output rob_ndx_t retire_ndx_o,
	output op_e retire_op_o
);

	logic new_v;
	rob_entry_t new_entry;
	rob_entry_t [ROB_ENTRIES-1:0] rob;
	rob_ndx_t head;
	rob_ndx_t tail;
	logic rob_full;
	complete_t retire;
	dispatch_t [DISPATCH_COUNT-1:0] disp;
	logic [NUM_FU-1:0] busy;
	complete_t [NUM_FU-1:0] comp;

	rob_alloc rob_alloc_inst (
		.clk(clk), .rst(rst),
		.alloc_valid_i(alloc_valid_i), .alloc_instr_i(alloc_instr_i),
		.rob_full_i(rob_full), .tail_i(tail), .retire_i(retire),
		.new_v_o(new_v), .new_entry_o(new_entry)
	);

	rob_store #(.DISPATCH_COUNT(DISPATCH_COUNT)) rob_store_inst (
		.clk(clk), .rst(rst),
		.new_v_i(new_v), .new_entry_i(new_entry),
		.disp_i(disp), .comp_i(comp),
		.rob_o(rob), .head_o(head), .tail_o(tail), .full_o(rob_full),
		.retire_o(retire), .retire_op_o(retire_op_o)
	);

	instr_dispatcher #(.DISPATCH_COUNT(DISPATCH_COUNT)) instr_dispatcher_inst (
		.clk(clk), .rst(rst),
		.rob_i(rob), .head_i(head), .busy_i(busy),
		.disp_o(disp)
	);

	fu_busy_tracker #(.DISPATCH_COUNT(DISPATCH_COUNT)) fu_busy_tracker_inst (
		.clk(clk), .rst(rst),
		.disp_i(disp),
		.busy_o(busy), .comp_o(comp)
	);

	// a full ROB is the only back-pressure toward the front end
	assign alloc_ready_o = !rob_full;
	assign dispatch_o = disp;
	assign retire_valid_o = retire.v;
	assign retire_ndx_o = retire.ndx;

endmodule

// ==== fu_busy_tracker.sv ====
`timescale 1ns/1ps

module fu_busy_tracker import dispatch_pkg::*; #(
	parameter int DISPATCH_COUNT = 4
) (
	input logic clk,
	input logic rst,
	input dispatch_t [DISPATCH_COUNT-1:0] disp_i,
	output logic [NUM_FU-1:0] busy_o,
	output complete_t [NUM_FU-1:0] comp_o
);

	// the multiplier has the longest latency and sets the counter width
	localparam int CNT_W = $clog2(LAT_MUL + 1);

	function automatic int unit_lat(int u);
		case (u)
			FU_MUL: return LAT_MUL;
			FU_MEM: return LAT_MEM;
			FU_FCU: return LAT_FCU;
			default: return LAT_ALU;
		endcase
	endfunction

	for (genvar u = 0; u < NUM_FU; u++) begin : g_unit
		localparam int LAT = unit_lat(u);

		logic [CNT_W-1:0] cnt_q;
		rob_ndx_t own_q;
		logic hit;
		rob_ndx_t hit_ndx;

		// at most one lane names a given unit in a cycle
		always_comb begin
			hit = 1'b0;
			hit_ndx = own_q;
			for (int l = 0; l < DISPATCH_COUNT; l++) begin
				if (disp_i[l].v && disp_i[l].fu == fu_id_t'(u)) begin
					hit = 1'b1;
					hit_ndx = disp_i[l].ndx;
				end
			end
		end

		always_ff @(posedge clk) begin
			if (rst)
				cnt_q <= '0;
			else if (hit)
				cnt_q <= CNT_W'(LAT);
			else if (cnt_q != '0)
				cnt_q <= cnt_q - 1'b1;
		end

		always_ff @(posedge clk) begin
			if (hit)
				own_q <= hit_ndx;
		end

		// the last busy cycle is also the completion cycle
		assign busy_o[u] = (cnt_q != '0);
		assign comp_o[u] = '{v: (cnt_q == CNT_W'(1)), ndx: own_q};
	end

	for (genvar l = 0; l < DISPATCH_COUNT; l++) begin : g_busy_chk
		a_no_busy_dispatch: assert property (@(posedge clk) disable iff (rst)
			disp_i[l].v |-> !busy_o[disp_i[l].fu])
			else $error("dispatch on lane %0d to busy unit %0d", l, disp_i[l].fu);
	end

endmodule

// ==== instr_dispatcher.sv ====
`timescale 1ns/1ps

module instr_dispatcher import dispatch_pkg::*; #(
	parameter int DISPATCH_COUNT = 4
) (
	input logic clk,
	input logic rst,
	input rob_entry_t [ROB_ENTRIES-1:0] rob_i,
	input rob_ndx_t head_i,
	input logic [NUM_FU-1:0] busy_i,
	output dispatch_t [DISPATCH_COUNT-1:0] disp_o
);

	dispatch_t [DISPATCH_COUNT-1:0] disp_d;
	dispatch_t [DISPATCH_COUNT-1:0] disp_q;

	// ======================================================================
	// oldest first scan of the ROB window
	// ======================================================================

	always_comb begin
		rob_ndx_t idx;
		rob_entry_t e;
		logic [NUM_FU-1:0] avail;
		logic br_pend;
		logic rdy;
		logic recent;
		logic take;
		fu_id_t unit;
		int cnt;

		disp_d = '0;
		cnt = 0;
		br_pend = 1'b0;
		// units picked last cycle only show busy from the next cycle on
		avail = ~busy_i;
		for (int l = 0; l < DISPATCH_COUNT; l++) begin
			if (disp_q[l].v)
				avail[disp_q[l].fu] = 1'b0;
		end

		for (int k = 0; k < ROB_ENTRIES; k++) begin
			idx = rob_ndx_t'(head_i + k);
			e = rob_i[idx];
			rdy = (!e.dep1_v || rob_i[e.dep1_ndx].done) &&
				(!e.dep2_v || rob_i[e.dep2_ndx].done);
			// the out bit of last cycle's picks lands one edge late
			recent = 1'b0;
			for (int l = 0; l < DISPATCH_COUNT; l++) begin
				if (disp_q[l].v && disp_q[l].ndx == idx)
					recent = 1'b1;
			end
			take = 1'b0;
			unit = FU_ALU0;
			if (e.v && !e.out && !e.done && rdy && !recent && cnt < DISPATCH_COUNT &&
				!(e.instr.op == OP_STORE && br_pend)) begin
				case (e.fcls)
					FC_ALU: begin
						// ALU0 goes first, ALU1 takes the overflow
						if (avail[FU_ALU0]) begin
							take = 1'b1;
							unit = FU_ALU0;
						end else if (avail[FU_ALU1]) begin
							take = 1'b1;
							unit = FU_ALU1;
						end
					end
					FC_MUL: begin
						take = avail[FU_MUL];
						unit = FU_MUL;
					end
					FC_MEM: begin
						take = avail[FU_MEM];
						unit = FU_MEM;
					end
					default: begin
						take = avail[FU_FCU];
						unit = FU_FCU;
					end
				endcase
			end
			if (take) begin
				avail[unit] = 1'b0;
				disp_d[cnt].v = 1'b1;
				disp_d[cnt].ndx = idx;
				disp_d[cnt].instr = e.instr;
				disp_d[cnt].fu = unit;
				cnt++;
			end
			// stores younger than an unresolved branch stay put
			if (e.v && e.instr.op == OP_BR && !e.done)
				br_pend = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int l = 0; l < DISPATCH_COUNT; l++)
				disp_q[l].v <= 1'b0;
		end else begin
			disp_q <= disp_d;
		end
	end

	assign disp_o = disp_q;

	// ======================================================================
	// lane checks
	// ======================================================================

	for (genvar i = 0; i < DISPATCH_COUNT; i++) begin : g_lane_a
		for (genvar j = i + 1; j < DISPATCH_COUNT; j++) begin : g_lane_b
			a_lanes_distinct: assert property (@(posedge clk) disable iff (rst)
				(disp_q[i].v && disp_q[j].v) |->
				(disp_q[i].fu != disp_q[j].fu && disp_q[i].ndx != disp_q[j].ndx))
				else $error("lanes %0d and %0d share a unit or an entry", i, j);
		end
	end

endmodule

// ==== rob_alloc.sv ====
`timescale 1ns/1ps

module rob_alloc import dispatch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic alloc_valid_i,
	input instr_t alloc_instr_i,
	input logic rob_full_i,
	input rob_ndx_t tail_i,
	input complete_t retire_i,
	output logic new_v_o,
	output rob_entry_t new_entry_o
);

	// last writer table, one slot per architectural register
	logic [NUM_AREGS-1:0] lw_v_q;
	rob_ndx_t lw_ndx_q [NUM_AREGS];
	logic writes_rd;

	function automatic fu_class_e op_class(op_e op);
		case (op)
			OP_NOP, OP_ADD, OP_SUB: return FC_ALU;
			OP_MUL: return FC_MUL;
			OP_LOAD, OP_STORE: return FC_MEM;
			OP_BR: return FC_FCU;
			default: return FC_ALU;
		endcase
	endfunction

	// a writer that retires this very cycle no longer counts as a producer
	function automatic logic live_writer(areg_t r);
		return lw_v_q[r] && !(retire_i.v && retire_i.ndx == lw_ndx_q[r]);
	endfunction

	assign new_v_o = alloc_valid_i && !rob_full_i;
	assign writes_rd = !(alloc_instr_i.op inside {OP_STORE, OP_BR});

	always_comb begin
		new_entry_o = '0;
		new_entry_o.v = 1'b1;
		new_entry_o.instr = alloc_instr_i;
		new_entry_o.fcls = op_class(alloc_instr_i.op);
		// the lookup sees the table before this instruction updates it
		new_entry_o.dep1_v = live_writer(alloc_instr_i.rs1);
		new_entry_o.dep1_ndx = lw_ndx_q[alloc_instr_i.rs1];
		new_entry_o.dep2_v = live_writer(alloc_instr_i.rs2);
		new_entry_o.dep2_ndx = lw_ndx_q[alloc_instr_i.rs2];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			lw_v_q <= '0;
		end else begin
			for (int r = 0; r < NUM_AREGS; r++) begin
				if (retire_i.v && lw_ndx_q[r] == retire_i.ndx)
					lw_v_q[r] <= 1'b0;
			end
			// newest writer wins, overriding any clear above
			if (new_v_o && writes_rd)
				lw_v_q[alloc_instr_i.rd] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (new_v_o && writes_rd)
			lw_ndx_q[alloc_instr_i.rd] <= tail_i;
	end

	// a live producer never sits in the free slot that the new entry takes
	a_dep_not_tail: assert property (@(posedge clk) disable iff (rst)
		new_v_o |-> !(new_entry_o.dep1_v && new_entry_o.dep1_ndx == tail_i) &&
			!(new_entry_o.dep2_v && new_entry_o.dep2_ndx == tail_i))
		else $error("new entry depends on its own slot %0d", tail_i);

endmodule

// ==== rob_store.sv ====
`timescale 1ns/1ps

module rob_store import dispatch_pkg::*; #(
	parameter int DISPATCH_COUNT = 4
) (
	input logic clk,
	input logic rst,
	input logic new_v_i,
	input rob_entry_t new_entry_i,
	input dispatch_t [DISPATCH_COUNT-1:0] disp_i,
	input complete_t [NUM_FU-1:0] comp_i,
	output rob_entry_t [ROB_ENTRIES-1:0] rob_o,
	output rob_ndx_t head_o,
	output rob_ndx_t tail_o,
	output logic full_o,
	output complete_t retire_o,
	output op_e retire_op_o
);

	rob_entry_t [ROB_ENTRIES-1:0] rob_q;
	rob_ndx_t head_q;
	rob_ndx_t tail_q;
	logic [$clog2(ROB_ENTRIES):0] count_q;
	logic retire_v;

	// the head leaves in the cycle after its done bit is written
	assign retire_v = rob_q[head_q].v && rob_q[head_q].done;

	// ======================================================================
	// slot state and pointers
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
			for (int i = 0; i < ROB_ENTRIES; i++)
				rob_q[i].v <= 1'b0;
		end else begin
			for (int l = 0; l < DISPATCH_COUNT; l++) begin
				if (disp_i[l].v)
					rob_q[disp_i[l].ndx].out <= 1'b1;
			end
			for (int u = 0; u < NUM_FU; u++) begin
				if (comp_i[u].v)
					rob_q[comp_i[u].ndx].done <= 1'b1;
			end
			if (retire_v) begin
				rob_q[head_q].v <= 1'b0;
				// consumers still waiting on the slot would otherwise see a
				// reused slot as their producer
				for (int i = 0; i < ROB_ENTRIES; i++) begin
					if (rob_q[i].dep1_ndx == head_q)
						rob_q[i].dep1_v <= 1'b0;
					if (rob_q[i].dep2_ndx == head_q)
						rob_q[i].dep2_v <= 1'b0;
				end
				head_q <= head_q + 1'b1;
			end
			// the tail slot is free, so this write overrides the loops above
			if (new_v_i) begin
				rob_q[tail_q] <= new_entry_i;
				tail_q <= tail_q + 1'b1;
			end
			case ({new_v_i, retire_v})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: ;
			endcase
		end
	end

	assign rob_o = rob_q;
	assign head_o = head_q;
	assign tail_o = tail_q;
	assign full_o = (count_q == ROB_ENTRIES);
	assign retire_o = '{v: retire_v, ndx: head_q};
	assign retire_op_o = rob_q[head_q].instr.op;

	// ======================================================================
	// checks against the dispatcher and the unit tracker
	// ======================================================================

	for (genvar l = 0; l < DISPATCH_COUNT; l++) begin : g_disp_chk
		a_disp_not_out: assert property (@(posedge clk) disable iff (rst)
			disp_i[l].v |-> rob_q[disp_i[l].ndx].v && !rob_q[disp_i[l].ndx].out)
			else $error("dispatch of ROB entry %0d that is already out", disp_i[l].ndx);
	end

	for (genvar u = 0; u < NUM_FU; u++) begin : g_comp_chk
		a_comp_out: assert property (@(posedge clk) disable iff (rst)
			comp_i[u].v |-> rob_q[comp_i[u].ndx].out)
			else $error("completion of ROB entry %0d that was never out", comp_i[u].ndx);
	end

endmodule

// ==== tb_dispatch_top.sv ====
`timescale 1ns/1ps

module tb_dispatch_top import dispatch_pkg::*; ();

	localparam int DISPATCH_COUNT = 4;
	localparam int MAX_SEQ = 256;
	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic rst;
	logic alloc_valid_i;
	instr_t alloc_instr_i;
	logic alloc_ready_o;
	dispatch_t [DISPATCH_COUNT-1:0] dispatch_o;
	logic retire_valid_o;
	rob_ndx_t retire_ndx_o;
	op_e retire_op_o;

	// reference model, indexed by allocation sequence number
	op_e m_op [MAX_SEQ];
	instr_t m_instr [MAX_SEQ];
	int m_dep1 [MAX_SEQ];
	int m_dep2 [MAX_SEQ];
	int m_disp_cyc [MAX_SEQ];
	int slot_seq [ROB_ENTRIES];
	int lw_seq [NUM_AREGS];
	int unit_last [NUM_FU];
	int alloc_cnt;
	int ret_cnt;
	int cyc;

	logic lanes_ok, dep_ok, store_ok, once_ok, busy_ok, retire_ok, ready_ok;

	dispatch_top #(.DISPATCH_COUNT(DISPATCH_COUNT)) dispatch_top_inst (
		.clk(clk), .rst(rst),
		.alloc_valid_i(alloc_valid_i), .alloc_instr_i(alloc_instr_i),
		.alloc_ready_o(alloc_ready_o), .dispatch_o(dispatch_o),
		.retire_valid_o(retire_valid_o), .retire_ndx_o(retire_ndx_o),
		.retire_op_o(retire_op_o)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ======================================================================
	// rules of the reference model
	// ======================================================================

	function automatic int op_latency(op_e op);
		case (op)
			OP_MUL: return LAT_MUL;
			OP_LOAD, OP_STORE: return LAT_MEM;
			OP_BR: return LAT_FCU;
			default: return LAT_ALU;
		endcase
	endfunction

	function automatic int unit_latency(fu_id_t fu);
		case (fu)
			FU_MUL: return LAT_MUL;
			FU_MEM: return LAT_MEM;
			FU_FCU: return LAT_FCU;
			default: return LAT_ALU;
		endcase
	endfunction

	// memory ops go to MEM, branches to FCU and the rest to either ALU
	function automatic logic fu_fits(op_e op, fu_id_t fu);
		case (op)
			OP_MUL: return fu == FU_MUL;
			OP_LOAD, OP_STORE: return fu == FU_MEM;
			OP_BR: return fu == FU_FCU;
			default: return fu == FU_ALU0 || fu == FU_ALU1;
		endcase
	endfunction

	// an entry counts as complete once its latency has run out after dispatch
	function automatic logic finished_by(int disp_cyc, op_e op, int now);
		return disp_cyc >= 0 && now > disp_cyc + op_latency(op);
	endfunction

	function automatic instr_t make_instr(op_e op, int rd, int rs1, int rs2);
		instr_t i;
		i.op = op;
		i.rd = areg_t'(rd);
		i.rs1 = areg_t'(rs1);
		i.rs2 = areg_t'(rs2);
		i.imm = 8'($urandom);
		return i;
	endfunction

	// the model follows the ports, one sample per rising edge
	always @(posedge clk) begin
		if (rst) begin
			cyc <= 0;
			alloc_cnt <= 0;
			ret_cnt <= 0;
			for (int r = 0; r < NUM_AREGS; r++)
				lw_seq[r] <= -1;
			for (int u = 0; u < NUM_FU; u++)
				unit_last[u] <= -100;
		end else begin
			cyc <= cyc + 1;
			for (int l = 0; l < DISPATCH_COUNT; l++) begin
				if (dispatch_o[l].v) begin
					m_disp_cyc[slot_seq[dispatch_o[l].ndx]] <= cyc;
					unit_last[dispatch_o[l].fu] <= cyc;
				end
			end
			if (retire_valid_o)
				ret_cnt <= ret_cnt + 1;
			if (alloc_valid_i && alloc_ready_o) begin
				// producers are the youngest older writers of each source
				m_op[alloc_cnt] <= alloc_instr_i.op;
				m_instr[alloc_cnt] <= alloc_instr_i;
				m_dep1[alloc_cnt] <= lw_seq[alloc_instr_i.rs1];
				m_dep2[alloc_cnt] <= lw_seq[alloc_instr_i.rs2];
				m_disp_cyc[alloc_cnt] <= -1;
				slot_seq[alloc_cnt % ROB_ENTRIES] <= alloc_cnt;
				if (alloc_instr_i.op != OP_STORE && alloc_instr_i.op != OP_BR)
					lw_seq[alloc_instr_i.rd] <= alloc_cnt;
				alloc_cnt <= alloc_cnt + 1;
			end
		end
	end

	always_comb begin
		int s;
		int prev;
		int n_alu;
		int n_one [NUM_FU];
		logic hole;
		lanes_ok = 1'b1;
		dep_ok = 1'b1;
		store_ok = 1'b1;
		once_ok = 1'b1;
		busy_ok = 1'b1;
		prev = -1;
		n_alu = 0;
		hole = 1'b0;
		for (int u = 0; u < NUM_FU; u++)
			n_one[u] = 0;
		for (int l = 0; l < DISPATCH_COUNT; l++) begin
			if (dispatch_o[l].v) begin
				s = slot_seq[dispatch_o[l].ndx];
				// lanes fill from lane 0 up, oldest first, and carry the model's instruction
				if (!fu_fits(dispatch_o[l].instr.op, dispatch_o[l].fu) ||
					dispatch_o[l].instr != m_instr[s] || s <= prev || hole)
					lanes_ok = 1'b0;
				if (dispatch_o[l].fu == FU_ALU0 || dispatch_o[l].fu == FU_ALU1)
					n_alu++;
				else if (dispatch_o[l].fu < NUM_FU)
					n_one[dispatch_o[l].fu]++;
				prev = s;
				if (m_disp_cyc[s] >= 0)
					once_ok = 1'b0;
				if (m_dep1[s] >= 0 && !finished_by(m_disp_cyc[m_dep1[s]], m_op[m_dep1[s]], cyc))
					dep_ok = 1'b0;
				if (m_dep2[s] >= 0 && !finished_by(m_disp_cyc[m_dep2[s]], m_op[m_dep2[s]], cyc))
					dep_ok = 1'b0;
				if (m_op[s] == OP_STORE) begin
					for (int b = ret_cnt; b < s; b++) begin
						if (m_op[b] == OP_BR && !finished_by(m_disp_cyc[b], OP_BR, cyc))
							store_ok = 1'b0;
					end
				end
				if (cyc - unit_last[dispatch_o[l].fu] < unit_latency(dispatch_o[l].fu))
					busy_ok = 1'b0;
			end else begin
				hole = 1'b1;
			end
		end
		if (n_alu > 2 || n_one[FU_MUL] > 1 || n_one[FU_MEM] > 1 || n_one[FU_FCU] > 1)
			lanes_ok = 1'b0;
	end

	// the head retires in allocation order and only after it completed
	always_comb begin
		retire_ok = 1'b1;
		if (retire_valid_o) begin
			if (ret_cnt >= alloc_cnt)
				retire_ok = 1'b0;
			else if (retire_ndx_o != rob_ndx_t'(ret_cnt % ROB_ENTRIES) ||
				retire_op_o != m_op[ret_cnt] ||
				!finished_by(m_disp_cyc[ret_cnt], m_op[ret_cnt], cyc))
				retire_ok = 1'b0;
		end
	end

	assign ready_ok = (alloc_ready_o == ((alloc_cnt - ret_cnt) < ROB_ENTRIES));

	// ======================================================================
	// checks
	// ======================================================================

	task automatic stop_with_failure(string line);
		$display("%s", line);
		$display("Simulation failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	a_lanes: assert property (@(posedge clk) disable iff (rst) lanes_ok)
		else stop_with_failure($sformatf("ERROR at %0t ns: lane order, class limit or unit", $time));
	a_deps: assert property (@(posedge clk) disable iff (rst) dep_ok)
		else stop_with_failure($sformatf("ERROR at %0t ns: dispatch before producer done", $time));
	a_store: assert property (@(posedge clk) disable iff (rst) store_ok)
		else stop_with_failure($sformatf("ERROR at %0t ns: store passed an open branch", $time));
	a_once: assert property (@(posedge clk) disable iff (rst) once_ok)
		else stop_with_failure($sformatf("ERROR at %0t ns: entry dispatched twice", $time));
	a_busy: assert property (@(posedge clk) disable iff (rst) busy_ok)
		else stop_with_failure($sformatf("ERROR at %0t ns: dispatch to a busy unit", $time));
	a_retire: assert property (@(posedge clk) disable iff (rst) retire_ok)
		else stop_with_failure($sformatf("ERROR at %0t ns: wrong retirement", $time));
	a_ready: assert property (@(posedge clk) disable iff (rst) ready_ok)
		else stop_with_failure($sformatf("ERROR at %0t ns: alloc_ready_o disagrees", $time));

	// ======================================================================
	// stimulus
	// ======================================================================

	// called at a falling edge, leaves the valid high for a following call
	task automatic alloc_instr(instr_t ins);
		int waited;
		waited = 0;
		alloc_valid_i = 1'b1;
		alloc_instr_i = ins;
		while (!alloc_ready_o && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!alloc_ready_o)
			stop_with_failure($sformatf("timeout after %0d cycles with the ROB full", waited));
		@(negedge clk);
	endtask

	task automatic drain_rob();
		int waited;
		waited = 0;
		alloc_valid_i = 1'b0;
		while (ret_cnt != alloc_cnt && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (ret_cnt != alloc_cnt)
			stop_with_failure($sformatf("timeout after %0d cycles waiting to retire", waited));
	endtask

	initial begin
		void'($urandom(32'h352041b5));
		rst = 1'b1;
		alloc_valid_i = 1'b0;
		alloc_instr_i = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// independent multiplies back to back share the one MUL unit
		for (int k = 1; k <= 3; k++)
			alloc_instr(make_instr(OP_MUL, k, 0, 0));
		// the branch waits on a multiply, so the store behind it has to wait too
		alloc_instr(make_instr(OP_MUL, 5, 0, 0));
		alloc_instr(make_instr(OP_BR, 0, 5, 5));
		alloc_instr(make_instr(OP_STORE, 0, 0, 0));
		drain_rob();

		// a slow multiply chain holds the head while the adds fill the ROB
		for (int k = 0; k < 4; k++)
			alloc_instr(make_instr(OP_MUL, 3, 3, 3));
		for (int k = 0; k < 8; k++)
			alloc_instr(make_instr(OP_ADD, 4, 3, 3));
		drain_rob();

		for (int k = 0; k < 150; k++) begin
			if ($urandom_range(0, 3) == 0) begin
				alloc_valid_i = 1'b0;
				@(negedge clk);
			end
			alloc_instr(make_instr(op_e'(3'($urandom_range(0, 6))), $urandom_range(0, 7),
				$urandom_range(0, 7), $urandom_range(0, 7)));
		end
		drain_rob();

		$display("Simulation completed successfully");
		$finish;
	end

endmodule
